// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cfg_ctrl -f src.f \
    -o tb_cfg_ctrl > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_cfg_ctrl > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: sim/tb_cfg_ctrl.sv
/*
 * Directed testbench for cfg_ctrl_top with a cfg_mgmt core model.
 * The core answers each access after 2 to 6 cycles. Reads return C0DE0000 plus dwaddr.
 */
module tb_cfg_ctrl import cfg_pkg::*; ();

    localparam int          MAX_CYCLES = 3000;     // Timer test about 500, the rest under 300
    localparam logic [15:0] PCIE_ID    = 16'h3AE5;

    logic          clk_pcie;
    logic          rst;
    logic          i_cmd_valid;
    logic [63:0]   i_cmd_word;
    pcie_id_t      i_pcie_id;
    cfg_mgmt_rsp_t i_mgmt_rsp;
    logic          o_cmd_ready;
    logic          o_rsp_valid;
    logic [31:0]   o_rsp_word;
    cfg_mgmt_req_t o_mgmt_req;
    logic          o_mgmt_rd_en;
    logic          o_mgmt_wr_en;

    cfg_mgmt_req_t rd_log [$];                    // Requests seen by the core model
    cfg_mgmt_req_t wr_log [$];
    int            cycles = 0;
    int            checks = 0;
    int            errors = 0;
    int            err_mark = 0;
    int            tests_run = 0;

    cfg_ctrl_top #(.CLEAR_PERIOD_RESET(62500)) dut (.*);

    initial begin
        clk_pcie = 1'b0;
        forever #20 clk_pcie = ~clk_pcie;
    end

    always @(posedge clk_pcie) cycles <= cycles + 1;

    initial begin : watchdog
        wait (cycles >= MAX_CYCLES);
        $display("Timeout: run stopped after %0d cycles without finishing", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // --------------------------------------------------
    // PCIe core model
    // --------------------------------------------------
    initial begin : core_model
        cfg_mgmt_req_t req;
        logic          is_read;
        int unsigned   lat;
        i_mgmt_rsp = '0;
        forever begin
            @(posedge clk_pcie);
            #5;
            if (o_mgmt_rd_en || o_mgmt_wr_en) begin
                req     = o_mgmt_req;
                is_read = o_mgmt_rd_en;
                if (is_read) begin
                    rd_log.push_back(req);
                end else begin
                    wr_log.push_back(req);
                    $display("Core write at %0t: dwaddr %h di %h byte_en %h",
                             $time, req.dwaddr, req.di, req.byte_en);
                end
                lat = 2 + ($urandom % 5);
                repeat (lat) @(posedge clk_pcie);
                #5;
                i_mgmt_rsp.rd_wr_done = 1'b1;
                i_mgmt_rsp.do_data    = is_read ? 32'hC0DE_0000 + 32'(req.dwaddr) : 32'h0;
                @(posedge clk_pcie);
                #5;
                i_mgmt_rsp = '0;                         // Done lasts one cycle
            end
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic tick();
        @(posedge clk_pcie);
        #5;
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    // Mask and value travel byte-swapped
    function automatic logic [63:0] cmd_word(input logic rd, input logic wr,
                                             input logic rw_bank, input int idx,
                                             input logic [15:0] mask,
                                             input logic [15:0] value);
        return {value[7:0], value[15:8], mask[7:0], mask[15:8],
                rw_bank, 14'(idx), 1'b0, 2'b00, wr, rd, 12'h000};
    endfunction

    task automatic send_cmd(input logic [63:0] word);
        while (!o_cmd_ready) tick();
        i_cmd_valid = 1'b1;
        i_cmd_word  = word;
        tick();
        i_cmd_valid = 1'b0;
    endtask

    task automatic write_word(input logic rw_bank, input int idx,
                              input logic [15:0] mask, input logic [15:0] value);
        send_cmd(cmd_word(1'b0, 1'b1, rw_bank, idx, mask, value));
        check_true(!o_rsp_valid, "read response raised after a write strobe");
    endtask

    task automatic read_word(input logic rw_bank, input int idx, output logic [15:0] data);
        send_cmd(cmd_word(1'b1, 1'b0, rw_bank, idx, 16'h0000, 16'h0000));
        check_true(o_rsp_valid, "no read response one cycle after the read strobe");
        check_val("o_rsp_word[31:16]", 64'(o_rsp_word[31:16]), 64'({rw_bank, 14'(idx), 1'b0}));
        data = {o_rsp_word[7:0], o_rsp_word[15:8]};
    endtask

    task automatic expect_word(input logic rw_bank, input int idx, input logic [15:0] exp);
        logic [15:0] data;
        read_word(rw_bank, idx, data);
        check_val($sformatf("%s word %0d", rw_bank ? "rw" : "ro", idx), 64'(data), 64'(exp));
    endtask

    function automatic int count_clears(input int from);
        int hits;
        hits = 0;
        for (int i = from; i < wr_log.size(); i++) begin
            if (wr_log[i].dwaddr == 10'd1 && wr_log[i].di == 32'hFF00_0407
                && wr_log[i].byte_en == 4'hB) hits++;
        end
        return hits;
    endfunction

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic reset_values();
        check_true(o_cmd_ready, "o_cmd_ready low after reset");
        check_true(!o_rsp_valid && !o_mgmt_rd_en && !o_mgmt_wr_en,
                   "response or enable output high after reset");
        expect_word(1'b1, 0, 16'h6745);
        expect_word(1'b0, 0, 16'h2301);
        expect_word(1'b1, 1, 16'h0008);
        expect_word(1'b1, 4, 16'hF000);
        expect_word(1'b0, 2, PCIE_ID);
        finish_test("reset_values");
    endtask

    task automatic register_access();
        logic [15:0] model [5];
        logic [15:0] mask;
        logic [15:0] value;
        int          w;
        model[2] = 16'h0000;
        model[3] = 16'h0000;
        model[4] = 16'hF000;
        repeat (12) begin
            w     = 2 + int'($urandom % 3);
            mask  = 16'($urandom);
            value = 16'($urandom);
            write_word(1'b1, w, mask, value);
            model[w] = (model[w] & ~mask) | (value & mask);
            expect_word(1'b1, w, model[w]);
        end
        write_word(1'b0, 2, 16'hFFFF, ~PCIE_ID);         // Read-only bank ignores it
        expect_word(1'b0, 2, PCIE_ID);
        expect_word(1'b1, 2, model[2]);                  // Same index in the rw bank untouched
        expect_word(1'b1, 20, 16'h0000);
        expect_word(1'b0, 20, 16'h0000);
        finish_test("register_access");
    endtask

    task automatic config_read();
        logic [15:0] data;
        int          rd_base;
        int          tries;
        rd_base = rd_log.size();
        write_word(1'b1, 4, 16'hFFFF, 16'hF009);         // byte_en F, dwaddr 9
        write_word(1'b1, 1, 16'h0001, 16'h0001);         // Start the read
        tries = 0;
        data  = 16'h0000;
        while (!data[11] && tries < 40) begin
            read_word(1'b0, 5, data);
            tries++;
        end
        check_true(data[11], "configuration read result never became valid");
        check_val("core read count", 64'(rd_log.size() - rd_base), 64'd1);
        if (rd_log.size() > rd_base) begin
            check_val("core read dwaddr", 64'(rd_log[rd_base].dwaddr), 64'd9);
        end
        expect_word(1'b0, 3, 16'h0009);
        expect_word(1'b0, 4, 16'hC0DE);
        expect_word(1'b0, 5, 16'hF809);                  // byte_en F, valid, dwaddr 9
        read_word(1'b1, 1, data);
        check_val("ctrl rd_en bit", 64'(data[0]), 64'd0);
        finish_test("config_read");
    endtask

    task automatic config_write_wait();
        cfg_mgmt_req_t exp_req;
        logic [31:0]   di;
        int            wr_base;
        int            n;
        logic          done_seen;
        logic          released;
        di      = $urandom;
        wr_base = wr_log.size();
        exp_req = {di, 10'h02C, 1'b0, 1'b0, 4'h3};
        write_word(1'b1, 2, 16'hFFFF, di[15:0]);
        write_word(1'b1, 3, 16'hFFFF, di[31:16]);
        write_word(1'b1, 4, 16'hFFFF, 16'h302C);         // byte_en 3, dwaddr 2C
        write_word(1'b1, 1, 16'h0006, 16'h0006);         // Wait bit and write start
        done_seen = 1'b0;
        released  = 1'b0;
        for (n = 0; n < 20 && !released; n++) begin
            @(negedge clk_pcie);                          // Away from the drive edge
            if (done_seen) begin
                check_true(o_cmd_ready, "o_cmd_ready still low the cycle after done");
                released = 1'b1;
            end else begin
                check_true(!o_cmd_ready, "o_cmd_ready high while the write was pending");
                done_seen = i_mgmt_rsp.rd_wr_done;
            end
        end
        check_true(released, "no done seen for the configuration write");
        tick();
        check_val("core write count", 64'(wr_log.size() - wr_base), 64'd1);
        if (wr_log.size() > wr_base) begin
            check_val("core write request", 64'(wr_log[wr_base]), 64'(exp_req));
        end
        write_word(1'b1, 1, 16'h0004, 16'h0000);         // Wait bit off
        finish_test("config_write_wait");
    endtask

    task automatic periodic_clear();
        int wr_base;
        int n;
        wr_base = wr_log.size();
        write_word(1'b1, 1, 16'h0010, 16'h0010);         // Command bits on too
        write_word(1'b1, 6, 16'hFFFF, 16'h0000);
        write_word(1'b1, 5, 16'hFFFF, 16'd30);
        n = 0;
        while (count_clears(wr_base) < 2 && n < 200) begin
            tick();
            n++;
        end
        check_true(count_clears(wr_base) >= 2, "fewer than two status-clear writes in 200 cycles");
        check_val("writes with other fields",
                  64'(wr_log.size() - wr_base - count_clears(wr_base)), 64'd0);
        write_word(1'b1, 1, 16'h0018, 16'h0000);         // Both enables off
        repeat (20) tick();                               // Access in flight may finish
        wr_base = wr_log.size();
        repeat (200) tick();
        check_val("writes after disable", 64'(wr_log.size() - wr_base), 64'd0);
        finish_test("periodic_clear");
    endtask

    initial begin : main_seq
        void'($urandom(32'h4f80));
        rst         = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_word  = 64'd0;
        i_pcie_id   = PCIE_ID;
        repeat (5) @(posedge clk_pcie);
        #5;
        rst = 1'b0;
        reset_values();
        register_access();
        config_read();
        config_write_wait();
        periodic_clear();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: source/cfg_ctrl_top.sv
/*
 * Configuration-management block, all in the clk_pcie domain.
 * Commands are one-cycle strobes gated by o_cmd_ready.
 */
module cfg_ctrl_top import cfg_pkg::*; #(
    parameter int unsigned CLEAR_PERIOD_RESET = 62500
) (
    input  logic          clk_pcie,
    input  logic          rst,
    input  logic          i_cmd_valid,
    input  logic [63:0]   i_cmd_word,
    input  pcie_id_t      i_pcie_id,
    input  cfg_mgmt_rsp_t i_mgmt_rsp,
    output logic          o_cmd_ready,
    output logic          o_rsp_valid,
    output logic [31:0]   o_rsp_word,
    output cfg_mgmt_req_t o_mgmt_req,
    output logic          o_mgmt_rd_en,
    output logic          o_mgmt_wr_en
);

    logic        start_rd;
    logic        start_wr;
    logic        wait_en;
    logic        start_ack;
    logic        fsm_idle;
    logic        cmd_block;
    cfg_rdres_t  rdres;
    logic [31:0] period;
    logic        timer_run;
    logic        fire;

    cfg_regfile #(
        .CLEAR_PERIOD_RESET (CLEAR_PERIOD_RESET)
    ) u_regfile (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_word   (i_cmd_word),
        .i_pcie_id    (i_pcie_id),
        .i_mgmt_rd_en (o_mgmt_rd_en),
        .i_mgmt_wr_en (o_mgmt_wr_en),
        .i_mgmt_done  (i_mgmt_rsp.rd_wr_done),
        .i_start_ack  (start_ack),
        .i_fsm_idle   (fsm_idle),
        .i_cmd_block  (cmd_block),
        .i_rdres      (rdres),
        .i_fire       (fire),
        .o_cmd_ready  (o_cmd_ready),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_word   (o_rsp_word),
        .o_mgmt_req   (o_mgmt_req),
        .o_start_rd   (start_rd),
        .o_start_wr   (start_wr),
        .o_wait_en    (wait_en),
        .o_period     (period),
        .o_timer_run  (timer_run)
    );

    cfg_mgmt_fsm u_mgmt_fsm (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .i_start_rd   (start_rd),
        .i_start_wr   (start_wr),
        .i_wait_en    (wait_en),
        .i_mgmt_req   (o_mgmt_req),
        .i_mgmt_rsp   (i_mgmt_rsp),
        .o_mgmt_rd_en (o_mgmt_rd_en),
        .o_mgmt_wr_en (o_mgmt_wr_en),
        .o_start_ack  (start_ack),
        .o_fsm_idle   (fsm_idle),
        .o_rdres      (rdres),
        .o_cmd_block  (cmd_block)
    );

    status_clear_timer #(
        .CLEAR_PERIOD_RESET (CLEAR_PERIOD_RESET)
    ) u_clear_timer (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .i_run    (timer_run),
        .i_period (period),
        .o_fire   (fire)
    );

endmodule

// File: source/cfg_mgmt_fsm.sv
/*
 * Runs one configuration-space access at a time over cfg_mgmt.
 * Read wins when both start bits are set. The core answers with one done pulse.
 */
module cfg_mgmt_fsm import cfg_pkg::*; (
    input  logic          clk_pcie,
    input  logic          rst,
    input  logic          i_start_rd,
    input  logic          i_start_wr,
    input  logic          i_wait_en,
    input  cfg_mgmt_req_t i_mgmt_req,
    input  cfg_mgmt_rsp_t i_mgmt_rsp,
    output logic          o_mgmt_rd_en,
    output logic          o_mgmt_wr_en,
    output logic          o_start_ack,
    output logic          o_fsm_idle,
    output cfg_rdres_t    o_rdres,
    output logic          o_cmd_block
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   done_active;

    assign o_fsm_idle  = (state_q == IDLE);
    assign o_start_ack = o_fsm_idle & (i_start_rd | i_start_wr);
    assign done_active = ~o_fsm_idle & i_mgmt_rsp.rd_wr_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_start_rd) state_d = READ;                 // Read has priority
                else if (i_start_wr) state_d = WRITE;
            end
            READ, WRITE: begin
                if (i_mgmt_rsp.rd_wr_done) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) state_q <= IDLE;
        else state_q <= state_d;
    end

    // Enables drop in the done cycle
    assign o_mgmt_rd_en = (state_q == READ) & ~i_mgmt_rsp.rd_wr_done;
    assign o_mgmt_wr_en = (state_q == WRITE) & ~i_mgmt_rsp.rd_wr_done;

    // --------------------------------------------------
    // Result capture
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (done_active) begin
            o_rdres.dwaddr  <= i_mgmt_req.dwaddr;
            o_rdres.byte_en <= i_mgmt_req.byte_en;
            o_rdres.data    <= i_mgmt_rsp.do_data;
        end
        if (rst) o_rdres.valid <= 1'b0;
        else if (o_start_ack) o_rdres.valid <= 1'b0;           // Stale once a new access starts
        else if (done_active) o_rdres.valid <= 1'b1;
    end

    // Held off while a start is pending or an access runs
    assign o_cmd_block = i_wait_en & (i_start_rd | i_start_wr | ~o_fsm_idle);

    a_en_onehot: assert property (@(posedge clk_pcie) disable iff (rst)
        !(o_mgmt_rd_en && o_mgmt_wr_en));

    // Core only completes an access that was issued
    a_done_in_access: assert property (@(posedge clk_pcie) disable iff (rst)
        i_mgmt_rsp.rd_wr_done |-> !o_fsm_idle);

endmodule

// File: source/cfg_pkg.sv
/*
 * Register map and shared types for the configuration-management block.
 * Bank sizes are in 16-bit words and the word layouts are fixed here.
 */
package cfg_pkg;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam int          RW_WORDS            = 8;
    localparam int          RO_WORDS            = 6;
    localparam logic [15:0] RW_MAGIC            = 16'h6745;
    localparam logic [15:0] RO_MAGIC            = 16'h2301;

    localparam int          CTRL_RD_EN          = 0;   // Start config read
    localparam int          CTRL_WR_EN          = 1;   // Start config write
    localparam int          CTRL_WAIT_COMPLETE  = 2;   // Stall commands during access
    localparam int          CTRL_STATUS_CL_EN   = 3;   // Timer clears status flags
    localparam int          CTRL_COMMAND_EN     = 4;   // Timer sets command bits

    // Periodic write into the command/status dword
    localparam logic [9:0]  STATUS_CLEAR_DWADDR = 10'd1;
    localparam logic [31:0] STATUS_CLEAR_DI     = 32'hFF00_0407;

    // --------------------------------------------------
    // Shared structs
    // --------------------------------------------------
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic        rw_bank;       // 1 selects the read-write bank
        logic [13:0] word_index;
        logic [15:0] mask;
        logic [15:0] value;
    } cfg_cmd_t;

    typedef struct packed {
        logic [31:0] di;
        logic [9:0]  dwaddr;
        logic        wr_readonly;
        logic        wr_rw1c_as_rw;
        logic [3:0]  byte_en;
    } cfg_mgmt_req_t;

    typedef struct packed {
        logic        rd_wr_done;    // One cycle, do_data valid with it
        logic [31:0] do_data;
    } cfg_mgmt_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [9:0]  dwaddr;
        logic [3:0]  byte_en;
        logic [31:0] data;
    } cfg_rdres_t;

    typedef struct packed {
        logic [7:0] bus;
        logic [4:0] device;
        logic [2:0] func;
    } pcie_id_t;

endpackage

// File: source/cfg_regfile.sv
/*
 * Command decode, both register banks and the read response path.
 * Writes to the read-only bank and to the reserved word are dropped.
 * The source must hold off i_cmd_valid while o_cmd_ready is low.
 */
module cfg_regfile import cfg_pkg::*; #(
    parameter int unsigned CLEAR_PERIOD_RESET = 62500
) (
    input  logic          clk_pcie,
    input  logic          rst,
    input  logic          i_cmd_valid,
    input  logic [63:0]   i_cmd_word,
    input  pcie_id_t      i_pcie_id,
    input  logic          i_mgmt_rd_en,
    input  logic          i_mgmt_wr_en,
    input  logic          i_mgmt_done,
    input  logic          i_start_ack,
    input  logic          i_fsm_idle,
    input  logic          i_cmd_block,
    input  cfg_rdres_t    i_rdres,
    input  logic          i_fire,
    output logic          o_cmd_ready,
    output logic          o_rsp_valid,
    output logic [31:0]   o_rsp_word,
    output cfg_mgmt_req_t o_mgmt_req,
    output logic          o_start_rd,
    output logic          o_start_wr,
    output logic          o_wait_en,
    output logic [31:0]   o_period,
    output logic          o_timer_run
);

    localparam logic [31:0] PERIOD_RST = CLEAR_PERIOD_RESET;

    cfg_cmd_t    cmd;
    logic [2:0]  idx;
    logic [15:0] rw_q [RW_WORDS];
    logic [15:0] ro_w [RO_WORDS];
    logic [15:0] rd_data;
    logic [3:0]  clear_be;

    // --------------------------------------------------
    // Command decode
    // --------------------------------------------------
    always_comb begin
        cmd.rd         = i_cmd_valid & i_cmd_word[12];
        cmd.wr         = i_cmd_valid & i_cmd_word[13];
        cmd.rw_bank    = i_cmd_word[31];
        cmd.word_index = i_cmd_word[30:17];                    // Byte address to word
        cmd.mask       = {i_cmd_word[39:32], i_cmd_word[47:40]};
        cmd.value      = {i_cmd_word[55:48], i_cmd_word[63:56]};
    end

    assign idx = cmd.word_index[2:0];

    // Read-only bank, built from live signals
    assign ro_w[0] = RO_MAGIC;
    assign ro_w[1] = {i_mgmt_done, 13'd0, i_mgmt_wr_en, i_mgmt_rd_en};
    assign ro_w[2] = i_pcie_id;
    assign ro_w[3] = i_rdres.data[15:0];
    assign ro_w[4] = i_rdres.data[31:16];
    assign ro_w[5] = {i_rdres.byte_en, i_rdres.valid, 1'b0, i_rdres.dwaddr};

    always_comb begin
        rd_data = 16'h0000;                                     // Past the end reads 0
        if (cmd.rw_bank) begin
            if (cmd.word_index < RW_WORDS) rd_data = rw_q[idx];
        end else if (cmd.word_index < RO_WORDS) begin
            rd_data = ro_w[idx];
        end
    end

    // Byte enables of the automatic write
    assign clear_be = {rw_q[1][CTRL_STATUS_CL_EN], 1'b0,
                       rw_q[1][CTRL_COMMAND_EN], rw_q[1][CTRL_COMMAND_EN]};

    // --------------------------------------------------
    // Read-write bank
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            for (int w = 0; w < RW_WORDS; w++) begin
                rw_q[w] <= 16'h0000;
            end
            rw_q[0] <= RW_MAGIC;
            rw_q[1] <= 16'h0008;                                // Status clear enabled
            rw_q[4] <= 16'hF000;                                // All byte enables
            rw_q[5] <= PERIOD_RST[15:0];
            rw_q[6] <= PERIOD_RST[31:16];
        end else begin
            // Ack clears the start bit the fsm took, read first
            if (i_start_ack) begin
                if (rw_q[1][CTRL_RD_EN]) rw_q[1][CTRL_RD_EN] <= 1'b0;
                else rw_q[1][CTRL_WR_EN] <= 1'b0;
            end
            if (i_fire) begin
                rw_q[1][CTRL_WR_EN] <= 1'b1;
                rw_q[2] <= STATUS_CLEAR_DI[15:0];
                rw_q[3] <= STATUS_CLEAR_DI[31:16];
                rw_q[4] <= {clear_be, 2'b00, STATUS_CLEAR_DWADDR};
            end
            // Masked bits win over the ack clear
            if (cmd.wr && cmd.rw_bank && cmd.word_index < RW_WORDS - 1) begin
                for (int b = 0; b < 16; b++) begin
                    if (cmd.mask[b]) rw_q[idx][b] <= cmd.value[b];
                end
            end
        end
    end

    // --------------------------------------------------
    // Read response
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) o_rsp_valid <= 1'b0;
        else o_rsp_valid <= cmd.rd;
    end

    always_ff @(posedge clk_pcie) begin
        if (cmd.rd) o_rsp_word <= {i_cmd_word[31:16], rd_data[7:0], rd_data[15:8]};
    end

    assign o_mgmt_req.di            = {rw_q[3], rw_q[2]};
    assign o_mgmt_req.dwaddr        = rw_q[4][9:0];
    assign o_mgmt_req.wr_readonly   = rw_q[4][10];
    assign o_mgmt_req.wr_rw1c_as_rw = rw_q[4][11];
    assign o_mgmt_req.byte_en       = rw_q[4][15:12];

    assign o_start_rd  = rw_q[1][CTRL_RD_EN];
    assign o_start_wr  = rw_q[1][CTRL_WR_EN];
    assign o_wait_en   = rw_q[1][CTRL_WAIT_COMPLETE];
    assign o_period    = {rw_q[6], rw_q[5]};
    assign o_cmd_ready = ~i_cmd_block;
    assign o_timer_run = (rw_q[1][CTRL_STATUS_CL_EN] | rw_q[1][CTRL_COMMAND_EN])
                       & ~i_cmd_valid & ~o_start_rd & ~o_start_wr & i_fsm_idle;

    // Source keeps to the ready handshake
    a_cmd_when_ready: assert property (@(posedge clk_pcie) disable iff (rst)
        i_cmd_valid |-> o_cmd_ready);

endmodule

// File: source/status_clear_timer.sv
/*
 * Counts run cycles and fires once the count reaches the period.
 * The count holds while i_run is low and restarts from 0 after a fire.
 */
module status_clear_timer #(
    parameter int unsigned CLEAR_PERIOD_RESET = 62500
) (
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_run,
    input  logic [31:0] i_period,
    output logic        o_fire
);

    logic [31:0] count_q;

    // Compare with >= so a shortened period still fires
    assign o_fire = i_run & (count_q >= i_period);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            count_q <= 32'd0;
        end else if (o_fire) begin
            count_q <= 32'd0;
        end else if (i_run) begin
            count_q <= count_q + 32'd1;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_count_in_range: assert property (@(posedge clk_pcie) disable iff (rst)
        i_run && $past(i_run) && $stable(i_period) |-> count_q <= i_period);

    // Period register comes out of reset at the top-level default
    a_period_reset: assert property (@(posedge clk_pcie)
        $fell(rst) |-> i_period == CLEAR_PERIOD_RESET);

endmodule

// File: src.f
source/cfg_pkg.sv
source/status_clear_timer.sv
source/cfg_mgmt_fsm.sv
source/cfg_regfile.sv
source/cfg_ctrl_top.sv
sim/tb_cfg_ctrl.sv
